// ==== hdl/uart_macros.svh ====
// Shared UART timing constants and register map, included by the RTL and the testbench
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Bit timing
`define UART_HALF_BIT 4         // Clocks per half bit, small for simulation
`define UART_FRAME_BITS 11      // Start, 8 data, parity, stop

// Register offsets on the 4-bit byte address
`define UART_ADDR_TXDATA 4'h0
`define UART_ADDR_RXDATA 4'h4   // Read only
`define UART_ADDR_STATUS 4'h8
`define UART_ADDR_CTRL   4'hC

// STATUS bit positions
`define UART_ST_TX_BUSY    0
`define UART_ST_RX_VALID   1
`define UART_ST_PARITY_ERR 2    // Sticky, write 1 to clear
`define UART_ST_OVERRUN    3    // Sticky, write 1 to clear

// CTRL bit positions
`define UART_CTRL_PARITY_ODD 0  // 0 even, 1 odd
`define UART_CTRL_LOOPBACK   1  // Receiver listens to txd
`define UART_CTRL_RX_IRQ_EN  2

`endif

// ==== hdl/uart_pkg.sv ====
// Types shared by the UART engines, the register block and the assertion module
package uart_pkg;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_INIT  = 2'b00,   // Clears counters once after reset
        RX_IDLE  = 2'b01,   // Waiting for a start edge
        RX_START = 2'b10,   // Half bit to reach mid start bit
        RX_BITS  = 2'b11    // Data, parity and stop samples
    } rx_state_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE  = 2'b00,   // Line held high
        TX_START = 2'b01,
        TX_DATA  = 2'b10,   // 8 data bits then parity
        TX_STOP  = 2'b11
    } tx_state_e;

    // AXI response codes, only the two the slave uses
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

endpackage

// ==== hdl/uart_rx.sv ====
// Serial receiver that samples each bit mid-period and reports the byte with a parity flag
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,              // Serial line, idles high
    input  logic       parity_odd,      // 1 = odd parity expected
    output logic [7:0] rx_data,
    output logic       rx_done,         // One cycle per frame
    output logic       rx_parity_error  // Only meaningful with rx_done
);
    import uart_pkg::*;

    // Counter spans one full bit period
    localparam int CNT_W    = $clog2(2 * `UART_HALF_BIT);
    localparam int STOP_IDX = `UART_FRAME_BITS - 2;     // Index of the stop sample

    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_HALF_BIT - 1);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(2 * `UART_HALF_BIT - 1);
    localparam logic [3:0]       STOP_BIT  = 4'(STOP_IDX);

    rx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;          // Samples taken since mid start bit
    logic [8:0]       shift_reg;        // Parity in bit 8, data LSB in bit 0
    logic             parity_bad;

    // Even mode wants XOR of all 9 bits at 0, odd mode wants 1
    assign parity_bad      = (^shift_reg) ^ parity_odd;
    assign rx_parity_error = rx_done & parity_bad;
    assign rx_data         = shift_reg[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_INIT;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;            // Pulse by default
            case (state)
                RX_INIT: begin
                    clk_cnt   <= '0;
                    bit_idx   <= '0;
                    shift_reg <= '0;
                    state     <= RX_IDLE;
                end

                RX_IDLE: begin
                    if (!rx) begin      // Start edge seen
                        clk_cnt <= CNT_W'(1);
                        bit_idx <= '0;
                        state   <= RX_START;
                    end
                end

                // Walk to the middle of the start bit
                RX_START: begin
                    if (clk_cnt >= HALF_LAST) begin
                        clk_cnt <= '0;
                        state   <= RX_BITS;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                // One sample per full bit, mid-bit
                RX_BITS: begin
                    if (clk_cnt >= FULL_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx >= STOP_BIT) begin
                            rx_done <= 1'b1;    // Stop sample, not checked
                            state   <= RX_IDLE;
                        end else begin
                            shift_reg <= {rx, shift_reg[8:1]};  // LSB first
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                default: state <= RX_INIT;
            endcase
        end
    end

endmodule

// ==== hdl/uart_tx.sv ====
// Serial transmitter that sends a byte as start, 8 data bits LSB first, parity and stop
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_start,    // One-cycle request, tx_data valid with it
    input  logic [7:0] tx_data,
    input  logic       parity_odd,
    output logic       txd,         // Idles high
    output logic       tx_busy      // Start bit through stop bit
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(2 * `UART_HALF_BIT);

    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(2 * `UART_HALF_BIT - 1);
    localparam logic [3:0]       LAST_BIT  = 4'(`UART_FRAME_BITS - 3);  // Parity bit index

    tx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;      // Bit currently on the line
    logic [8:0]       shift_reg;    // Parity above the byte
    logic             bit_end;

    assign bit_end = (clk_cnt == FULL_LAST);
    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;   // Free runs, realigned on start
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_start) begin
                        txd   <= 1'b0;  // Start bit
                        state <= TX_START;
                    end
                end

                TX_START: begin
                    if (bit_end) begin
                        txd     <= shift_reg[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end

                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == LAST_BIT) begin
                            txd   <= 1'b1;  // Stop bit
                            state <= TX_STOP;
                        end else begin
                            txd     <= shift_reg[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end

                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;   // txd already high
                    end
                end

                default: state <= TX_IDLE;
            endcase
        end
    end

    // Frame payload, loaded on start and shifted per bit
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shift_reg <= {(^tx_data) ^ parity_odd, tx_data};
        end else if (state == TX_DATA && bit_end) begin
            shift_reg <= {1'b0, shift_reg[8:1]};
        end
    end

endmodule

// ==== hdl/uart_regs.sv ====
// AXI4-Lite register block joining the UART transmitter and receiver, with loopback and IRQ
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic [3:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output uart_pkg::axi_resp_e bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output uart_pkg::axi_resp_e rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic                rxd,            // External serial input
    input  logic                txd,            // Transmitter output, for loopback
    output logic                rx_line,        // Line the receiver samples
    input  logic                tx_busy,
    output logic                tx_start,
    output logic [7:0]          tx_data,
    output logic                parity_odd,
    input  logic [7:0]          rx_data,
    input  logic                rx_done,
    input  logic                rx_parity_error,
    output logic                irq
);
    import uart_pkg::*;

    logic [2:0]  ctrl;
    logic [7:0]  rx_byte;           // Last received byte
    logic        rx_valid;
    logic        parity_err;
    logic        overrun;
    logic [31:0] status_word;
    logic        wr_take;
    logic        wr_hs;
    logic        rd_hs;
    logic        tx_busy_any;
    logic        wr_tx_ok;
    logic        wr_status;
    logic        clr_rx_valid;

    assign wr_take      = awvalid & wvalid & ~bvalid & ~awready;
    assign wr_hs        = awready & awvalid & wready & wvalid;
    assign rd_hs        = arready & arvalid;
    assign tx_busy_any  = tx_busy | tx_start;   // Busy rises a cycle after the start pulse
    assign wr_tx_ok     = wr_hs && (awaddr == `UART_ADDR_TXDATA) && wstrb[0] && !tx_busy_any;
    assign wr_status    = wr_hs && (awaddr == `UART_ADDR_STATUS) && wstrb[0];
    assign clr_rx_valid = rd_hs && (araddr == `UART_ADDR_RXDATA);
    assign parity_odd   = ctrl[`UART_CTRL_PARITY_ODD];
    assign rx_line      = ctrl[`UART_CTRL_LOOPBACK] ? txd : rxd;

    always_comb begin
        status_word = '0;
        status_word[`UART_ST_TX_BUSY]    = tx_busy_any;
        status_word[`UART_ST_RX_VALID]   = rx_valid;
        status_word[`UART_ST_PARITY_ERR] = parity_err;
        status_word[`UART_ST_OVERRUN]    = overrun;
    end

    // Write address and data taken together, one response outstanding
    always_ff @(posedge clk) begin
        if (reset) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            tx_start <= 1'b0;
            ctrl     <= '0;
        end else begin
            awready  <= wr_take;
            wready   <= wr_take;
            tx_start <= wr_tx_ok;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs && awaddr == `UART_ADDR_CTRL && wstrb[0]) begin
                ctrl <= wdata[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            case (awaddr)
                `UART_ADDR_TXDATA: bresp <= tx_busy_any ? SLVERR : OKAY;  // Byte dropped
                `UART_ADDR_RXDATA: bresp <= SLVERR;                       // Read only
                `UART_ADDR_STATUS,
                `UART_ADDR_CTRL:   bresp <= OKAY;
                default:           bresp <= SLVERR;
            endcase
        end
        if (wr_tx_ok) begin
            tx_data <= wdata[7:0];
        end
        if (rx_done) begin
            rx_byte <= rx_data;     // Newest byte always wins
        end
    end

    // Receive flags, set beats clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            overrun    <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (rx_done) begin
                rx_valid <= 1'b1;
            end else if (clr_rx_valid) begin
                rx_valid <= 1'b0;
            end
            // Unread byte being replaced
            if (rx_done && rx_valid && !clr_rx_valid) begin
                overrun <= 1'b1;
            end else if (wr_status && wdata[`UART_ST_OVERRUN]) begin
                overrun <= 1'b0;
            end
            if (rx_done && rx_parity_error) begin
                parity_err <= 1'b1;
            end else if (wr_status && wdata[`UART_ST_PARITY_ERR]) begin
                parity_err <= 1'b0;
            end
            irq <= rx_valid & ctrl[`UART_CTRL_RX_IRQ_EN];
        end
    end

    // Read channel, arready drops while a response waits
    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ~(rd_hs | (rvalid & ~rready));
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rresp <= OKAY;
            case (araddr)
                `UART_ADDR_TXDATA: rdata <= {24'h0, tx_data};
                `UART_ADDR_RXDATA: rdata <= {24'h0, rx_byte};
                `UART_ADDR_STATUS: rdata <= status_word;
                `UART_ADDR_CTRL:   rdata <= {29'h0, ctrl};
                default: begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end
            endcase
        end
    end

endmodule

// ==== hdl/uart_core.sv ====
// UART top level with an AXI4-Lite slave port, connecting the register block and both engines
`timescale 1ns/1ps

module uart_core (
    input  logic                clk,
    input  logic                reset,
    input  logic [3:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output uart_pkg::axi_resp_e bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output uart_pkg::axi_resp_e rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic                rxd,
    output logic                txd,
    output logic                irq
);

    // Register block to transmitter
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       parity_odd;     // Shared by both engines

    // Receiver to register block
    logic       rx_line;        // rxd or txd in loopback
    logic [7:0] rx_data;
    logic       rx_done;
    logic       rx_parity_error;

    uart_regs u_regs (
        .clk             (clk),
        .reset           (reset),
        .awaddr          (awaddr),
        .awvalid         (awvalid),
        .awready         (awready),
        .wdata           (wdata),
        .wstrb           (wstrb),
        .wvalid          (wvalid),
        .wready          (wready),
        .bresp           (bresp),
        .bvalid          (bvalid),
        .bready          (bready),
        .araddr          (araddr),
        .arvalid         (arvalid),
        .arready         (arready),
        .rdata           (rdata),
        .rresp           (rresp),
        .rvalid          (rvalid),
        .rready          (rready),
        .rxd             (rxd),
        .txd             (txd),
        .rx_line         (rx_line),
        .tx_busy         (tx_busy),
        .tx_start        (tx_start),
        .tx_data         (tx_data),
        .parity_odd      (parity_odd),
        .rx_data         (rx_data),
        .rx_done         (rx_done),
        .rx_parity_error (rx_parity_error),
        .irq             (irq)
    );

    uart_tx u_tx (
        .clk        (clk),
        .reset      (reset),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .parity_odd (parity_odd),
        .txd        (txd),
        .tx_busy    (tx_busy)
    );

    uart_rx u_rx (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx_line),
        .parity_odd      (parity_odd),
        .rx_data         (rx_data),
        .rx_done         (rx_done),
        .rx_parity_error (rx_parity_error)
    );

endmodule

// ==== test/uart_sva.sv ====
// Assertions on the UART AXI response channels and serial idle level, bound into uart_regs
`timescale 1ns/1ps

module uart_sva (
    input logic        clk,
    input logic        reset,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        txd,
    input logic        tx_busy
);

    // Responses wait for their ready
    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready was seen");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready was seen");

    a_rdata_stable: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> $stable(rdata))
        else $error("rdata changed while the read response was waiting");

    // Idle transmitter keeps the line high
    a_txd_idle: assert property (@(posedge clk) disable iff (reset)
        !tx_busy |-> txd)
        else $error("txd low while the transmitter is idle");

endmodule

// Register block carries the AXI responses and the transmitter's txd and tx_busy
bind uart_regs uart_sva u_sva (
    .clk     (clk),
    .reset   (reset),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .txd     (txd),
    .tx_busy (tx_busy)
);

// ==== test/uart_tb.sv ====
// Directed testbench for uart_core, driving the AXI4-Lite port and both serial lines
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tb;
    import uart_pkg::*;

    localparam int BIT_CLKS   = 2 * `UART_HALF_BIT;
    localparam int FRAME_CLKS = `UART_FRAME_BITS * BIT_CLKS;
    localparam int TIMEOUT    = 40 * FRAME_CLKS * 2;    // 40 frames with double margin

    logic        clk, reset;
    logic [3:0]  awaddr, araddr;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic        arvalid, arready, rvalid, rready;
    axi_resp_e   bresp, rresp;
    logic        rxd, txd, irq;
    int          cycle_count;
    logic [15:0] lfsr_state;
    string       current_test;

    uart_core DUT (
        .clk (clk), .reset (reset),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .rxd (rxd), .txd (txd), .irq (irq)
    );

    always #10 clk = ~clk;      // 20 ns period

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
            $display("STATUS: FAIL");
            $fatal(1, "Run stopped on timeout");
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s, %s: expected %h, actual %h",
                     current_test, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch in %s", current_test);
        end
    endtask

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            b[i]       = lfsr_state[0];
        end
    endtask

    // Parity bit that makes the count of ones over data and parity match the mode
    function automatic logic parity_bit(input logic [7:0] b, input logic odd);
        int ones;
        ones = $countones(b);
        return ((ones + 1) % 2) == int'(odd);
    endfunction

    // Called and returns on a falling edge
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);         // Handshake edge passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);         // Response held one cycle before bready
        bready  = 1'b1;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        @(negedge clk);         // Response held one cycle before rready
        rready  = 1'b1;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                                input logic [1:0] exp_resp, input string what);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check(what, exp_resp, resp);
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check({what, " resp"}, OKAY, resp);
        check(what, expected, data);
    endtask

    // Poll STATUS until a bit reaches the wanted level
    task automatic wait_status(input int bit_pos, input logic level);
        logic [31:0] data;
        logic [1:0]  resp;
        data = {32{~level}};
        while (data[bit_pos] !== level) axi_read(`UART_ADDR_STATUS, data, resp);
    endtask

    // Frame on rxd with the mode's parity bit or its inverse
    task automatic serial_send(input logic [7:0] b, input logic odd, input logic bad);
        logic [10:0] frame;
        int i;
        frame = {1'b1, parity_bit(b, odd) ^ bad, b, 1'b0};
        for (i = 0; i < `UART_FRAME_BITS; i++) begin
            rxd = frame[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    task automatic serial_capture(output logic [10:0] frame);
        int i;
        @(negedge txd);
        repeat (`UART_HALF_BIT) @(negedge clk);     // Mid start bit
        for (i = 0; i < `UART_FRAME_BITS; i++) begin
            frame[i] = txd;
            if (i < `UART_FRAME_BITS - 1) repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    task automatic check_frame(input logic [10:0] frame, input logic [7:0] b,
                               input logic odd);
        check("start bit", 1'b0, frame[0]);
        check("data bits", b, frame[8:1]);
        check("parity bit", parity_bit(b, odd), frame[9]);
        check("stop bit", 1'b1, frame[10]);
    endtask

    task automatic test_reset_and_errors();
        logic [31:0] data;
        logic [1:0]  resp;
        current_test = "reset_and_errors";
        check("awready after reset", 1'b0, awready);
        check("wready after reset", 1'b0, wready);
        check("arready after reset", 1'b1, arready);
        check("bvalid after reset", 1'b0, bvalid);
        check("rvalid after reset", 1'b0, rvalid);
        read_expect(`UART_ADDR_STATUS, 32'h0, "STATUS after reset");
        read_expect(`UART_ADDR_CTRL, 32'h0, "CTRL after reset");
        check("txd after reset", 1'b1, txd);
        check("irq after reset", 1'b0, irq);
        axi_read(4'h6, data, resp);
        check("unmapped read resp", SLVERR, resp);
        check("unmapped read data", 32'h0, data);
        write_expect(4'h6, 32'hA5, SLVERR, "unmapped write resp");
        write_expect(`UART_ADDR_RXDATA, 32'h5A, SLVERR, "RXDATA write resp");
    endtask

    task automatic test_transmit();
        logic [7:0]  b;
        logic [10:0] frame;
        int odd, n;
        current_test = "transmit";
        for (odd = 0; odd < 2; odd++) begin
            write_expect(`UART_ADDR_CTRL, odd, OKAY, "CTRL write");
            for (n = 0; n < 3; n++) begin
                random_byte(b);
                fork
                    serial_capture(frame);
                    write_expect(`UART_ADDR_TXDATA, b, OKAY, "TXDATA write");
                join
                check_frame(frame, b, odd[0]);
                wait_status(`UART_ST_TX_BUSY, 1'b0);
            end
        end
    endtask

    task automatic test_tx_busy_drop();
        logic [7:0]  first, second;
        logic [10:0] frame;
        current_test = "tx_busy_drop";
        write_expect(`UART_ADDR_CTRL, 32'h0, OKAY, "CTRL write");
        random_byte(first);
        random_byte(second);
        fork
            serial_capture(frame);
            begin
                write_expect(`UART_ADDR_TXDATA, first, OKAY, "first TXDATA write");
                read_expect(`UART_ADDR_STATUS, 32'h1, "STATUS while busy");
                write_expect(`UART_ADDR_TXDATA, second, SLVERR, "TXDATA write while busy");
            end
        join
        check_frame(frame, first, 1'b0);
        wait_status(`UART_ST_TX_BUSY, 1'b0);
        repeat (FRAME_CLKS) begin       // Dropped byte must never reach the line
            @(negedge clk);
            check("line idle after dropped byte", 1'b1, txd);
        end
    endtask

    task automatic test_receive();
        logic [7:0] b;
        int odd, n;
        current_test = "receive";
        for (odd = 0; odd < 2; odd++) begin
            write_expect(`UART_ADDR_CTRL, odd, OKAY, "CTRL write");
            for (n = 0; n < 3; n++) begin
                random_byte(b);
                serial_send(b, odd[0], 1'b0);
                wait_status(`UART_ST_RX_VALID, 1'b1);
                read_expect(`UART_ADDR_STATUS, 32'h2, "STATUS with byte waiting");
                read_expect(`UART_ADDR_RXDATA, b, "RXDATA");
                read_expect(`UART_ADDR_STATUS, 32'h0, "STATUS after RXDATA read");
            end
        end
    endtask

    task automatic test_parity_error();
        logic [7:0] b;
        current_test = "parity_error";
        write_expect(`UART_ADDR_CTRL, 32'h0, OKAY, "CTRL write");
        random_byte(b);
        serial_send(b, 1'b0, 1'b1);     // Inverted parity bit
        wait_status(`UART_ST_RX_VALID, 1'b1);
        read_expect(`UART_ADDR_STATUS, 32'h6, "STATUS with parity error");
        read_expect(`UART_ADDR_RXDATA, b, "RXDATA");
        write_expect(`UART_ADDR_STATUS, 32'h4, OKAY, "STATUS clear write");
        read_expect(`UART_ADDR_STATUS, 32'h0, "STATUS after clear");
    endtask

    task automatic test_overrun();
        logic [7:0] b1, b2;
        current_test = "overrun";
        random_byte(b1);
        random_byte(b2);
        serial_send(b1, 1'b0, 1'b0);
        serial_send(b2, 1'b0, 1'b0);    // No read in between
        wait_status(`UART_ST_RX_VALID, 1'b1);
        read_expect(`UART_ADDR_STATUS, 32'hA, "STATUS with overrun");
        read_expect(`UART_ADDR_RXDATA, b2, "RXDATA holds newest byte");
        write_expect(`UART_ADDR_STATUS, 32'h8, OKAY, "STATUS clear write");
        read_expect(`UART_ADDR_STATUS, 32'h0, "STATUS after clear");
    endtask

    task automatic test_loopback_irq();
        logic [7:0] b, noise;
        current_test = "loopback_irq";
        write_expect(`UART_ADDR_CTRL, 32'h6, OKAY, "CTRL loopback and irq enable");
        random_byte(b);
        random_byte(noise);
        fork
            write_expect(`UART_ADDR_TXDATA, b, OKAY, "TXDATA write");
            serial_send(noise, 1'b0, 1'b0);     // Must be ignored on rxd
        join
        wait_status(`UART_ST_RX_VALID, 1'b1);
        wait_status(`UART_ST_TX_BUSY, 1'b0);
        check("irq with byte waiting", 1'b1, irq);
        read_expect(`UART_ADDR_STATUS, 32'h2, "STATUS single loopback byte");
        read_expect(`UART_ADDR_RXDATA, b, "RXDATA loopback byte");
        @(negedge clk);
        check("irq after RXDATA read", 1'b0, irq);
        write_expect(`UART_ADDR_CTRL, 32'h0, OKAY, "CTRL restore");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        rxd         = 1'b1;     // Idle line
        cycle_count = 0;
        lfsr_state  = 16'd39902;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset_and_errors();
        test_transmit();
        test_tx_busy_drop();
        test_receive();
        test_parity_error();
        test_overrun();
        test_loopback_irq();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_regs.sv
hdl/uart_core.sv
test/uart_sva.sv
test/uart_tb.sv
